//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
	-f vxe.f --top-module tb_vxe -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_vxe > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi
exit 0

//--- src/vxe_cu.sv
/*
 * Control unit. Fetches from the start address until END or a fault,
 * keeps the last executed address, instruction and fault code.
 */
`timescale 1ns/1ns
`default_nettype none

module vxe_cu (
	input  wire                 clk,
	input  wire                 nrst,
	input  wire                 i_start,
	input  vxe_pkg::pgm_addr_t  i_pgm_addr,
	output logic                o_busy,
	output vxe_pkg::pgm_addr_t  o_last_instr_addr,
	output vxe_pkg::instr_t     o_last_instr_data,
	output vxe_pkg::fault_t     o_fault,
	output logic                o_done_evt,
	output logic                o_fault_evt,
	vxe_fetch_if.master         fetch
);
	import vxe_pkg::*;

	cu_state_t state;
	pgm_addr_t pc;		/* Current fetch address. */
	logic      in_range;	/* pc below MEM_DEPTH words. */

	assign in_range = (pc[$bits(pgm_addr_t)-1:3] < 34'(MEM_DEPTH));
	assign o_busy = (state != CU_IDLE);

	/* Request held until ready. */
	assign fetch.req_valid = (state == CU_FETCH) && in_range;
	assign fetch.req_idx = pc[$bits(mem_idx_t)+2:3];

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			state <= CU_IDLE;
			pc <= '0;
			o_last_instr_addr <= '0;
			o_last_instr_data <= '0;
			o_fault <= '0;
			o_done_evt <= 1'b0;
			o_fault_evt <= 1'b0;
		end
		else
		begin
			o_done_evt <= 1'b0;
			o_fault_evt <= 1'b0;
			case (state)
			CU_IDLE:
			begin
				if (i_start)
				begin
					pc <= i_pgm_addr;
					o_fault <= '0;	/* New run. */
					state <= CU_FETCH;
				end
			end
			CU_FETCH:
			begin
				if (!in_range)
				begin
					o_fault <= 2'b10;		/* Beyond memory. */
					o_last_instr_addr <= pc;	/* Offending address. */
					o_fault_evt <= 1'b1;
					state <= CU_IDLE;
				end
				else if (fetch.req_ready)
					state <= CU_WAIT;	/* Transfer done. */
			end
			CU_WAIT:
			begin
				if (fetch.rsp_valid)
				begin
					o_last_instr_addr <= pc;
					o_last_instr_data <= fetch.rsp_data;
					state <= CU_DECODE;
				end
			end
			CU_DECODE:
			begin
				/* Opcode sits in the top byte. */
				case (o_last_instr_data[63:56])
				OP_NOP:
				begin
					pc <= pc + pgm_addr_t'(8);	/* Next word. */
					state <= CU_FETCH;
				end
				OP_END:
				begin
					o_done_evt <= 1'b1;
					state <= CU_IDLE;
				end
				default:
				begin
					o_fault <= 2'b01;	/* Illegal opcode. */
					o_fault_evt <= 1'b1;
					state <= CU_IDLE;
				end
				endcase
			end
			default: state <= CU_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/vxe_fetch_if.sv
/*
 * Instruction fetch path from the control unit to the memory hub.
 * Valid/ready request, response one cycle after the transfer.
 */
`timescale 1ns/1ns
`default_nettype none

interface vxe_fetch_if;
	import vxe_pkg::*;

	logic     req_valid;	/* Request pending. */
	mem_idx_t req_idx;	/* Word to read. */
	logic     req_ready;	/* Hub grants the fetch port. */
	logic     rsp_valid;	/* One cycle after transfer. */
	instr_t   rsp_data;

	/* Control unit side. */
	modport master(output req_valid, output req_idx,
		input req_ready, input rsp_valid, input rsp_data);

	/* Memory hub side. */
	modport slave(input req_valid, input req_idx,
		output req_ready, output rsp_valid, output rsp_data);
endinterface

`default_nettype wire

//--- src/vxe_intu.sv
/*
 * Interrupt unit. Sticky pending bits set by event pulses and
 * cleared by host acknowledge, masked onto one interrupt line.
 */
`timescale 1ns/1ns
`default_nettype none

module vxe_intu (
	input  wire             clk,
	input  wire             nrst,
	input  vxe_pkg::intr_t  i_events,
	input  vxe_pkg::intr_t  i_msk,
	input  wire             i_ack_vld,
	input  vxe_pkg::intr_t  i_ack,
	output vxe_pkg::intr_t  o_raw,
	output vxe_pkg::intr_t  o_act,
	output logic            o_irq
);
	import vxe_pkg::*;

	intr_t clr;	/* Bits to clear this cycle. */

	assign clr = i_ack_vld ? i_ack : '0;

	/* Set wins over clear. */
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			o_raw <= '0;
		else
			o_raw <= (o_raw & ~clr) | i_events;
	end

	assign o_act = o_raw & i_msk;	/* Masked view. */
	assign o_irq = |o_act;		/* Any active bit. */

endmodule

`default_nettype wire

//--- src/vxe_memhub.sv
/*
 * Program memory with two users. Master select 0 gives it to the
 * host write port, 1 gives it to the control unit fetch port.
 */
`timescale 1ns/1ns
`default_nettype none

module vxe_memhub (
	input  wire                clk,
	input  wire                i_mas_sel,
	input  vxe_pkg::mem_idx_t  i_host_widx,
	input  vxe_pkg::instr_t    i_host_wdata,
	input  wire                i_host_wenable,
	output logic               o_wr_ignored_evt,
	vxe_fetch_if.slave         fetch
);
	import vxe_pkg::*;

	instr_t mem [MEM_DEPTH];	/* Program words. */
	logic   xfer;			/* Fetch request accepted. */

	assign fetch.req_ready = i_mas_sel;	/* Only while CU owns memory. */
	assign xfer = fetch.req_valid & fetch.req_ready;

	/* Host write, dropped while the CU owns memory. */
	always_ff @(posedge clk)
	begin
		if (i_host_wenable && !i_mas_sel)
			mem[i_host_widx] <= i_host_wdata;
	end

	assign o_wr_ignored_evt = i_host_wenable & i_mas_sel;

	/* One-cycle read latency. */
	always_ff @(posedge clk)
	begin
		fetch.rsp_valid <= xfer;
		if (xfer)
			fetch.rsp_data <= mem[fetch.req_idx];
	end

endmodule

`default_nettype wire

//--- src/vxe_pkg.sv
/*
 * Shared widths, register map, opcodes and FSM states of the vector engine.
 * Modules import it inside their body and use scoped names in their ports.
 */
`default_nettype none

package vxe_pkg;

	typedef logic [9:0]  reg_idx_t;		/* Register index. */
	typedef logic [31:0] word_t;		/* Bus data word. */
	typedef logic [36:0] pgm_addr_t;	/* Byte address, low 3 bits zero. */
	typedef logic [63:0] instr_t;		/* Opcode in bits 63..56. */
	typedef logic [7:0]  mem_idx_t;		/* Program memory word index. */
	typedef logic [3:0]  intr_t;		/* Done, fault, start ign., write ign. */
	typedef logic [1:0]  fault_t;		/* Illegal opcode, address range. */

	/* Control unit states. */
	typedef enum logic [1:0] {
		CU_IDLE,
		CU_FETCH,
		CU_WAIT,
		CU_DECODE
	} cu_state_t;

	localparam int MEM_DEPTH = 256;
	localparam word_t VXENGINE_ID = 32'h5658_4531;
	localparam logic [7:0] OP_NOP = 8'h00;
	localparam logic [7:0] OP_END = 8'h01;

	/* Register indices. */
	localparam reg_idx_t REG_ID                  = 10'd0;
	localparam reg_idx_t REG_CTRL                = 10'd1;
	localparam reg_idx_t REG_STATUS              = 10'd2;
	localparam reg_idx_t REG_INTR_ACT            = 10'd3;
	localparam reg_idx_t REG_INTR_MSK            = 10'd4;
	localparam reg_idx_t REG_INTR_RAW            = 10'd5;
	localparam reg_idx_t REG_PGM_ADDR_LO         = 10'd6;
	localparam reg_idx_t REG_PGM_ADDR_HI         = 10'd7;
	localparam reg_idx_t REG_START               = 10'd8;
	localparam reg_idx_t REG_FAULT_INSTR_ADDR_LO = 10'd9;
	localparam reg_idx_t REG_FAULT_INSTR_ADDR_HI = 10'd10;
	localparam reg_idx_t REG_FAULT_INSTR_LO      = 10'd11;
	localparam reg_idx_t REG_FAULT_INSTR_HI      = 10'd12;
	localparam reg_idx_t REG_FAULT_CODE          = 10'd13;

	localparam word_t DEAD_WORD = 32'hdead_beef;	/* Unused index or no read. */
	localparam word_t WO_WORD   = 32'hffff_ffff;	/* Write-only register. */

endpackage

`default_nettype wire

//--- src/vxe_regio.sv
/*
 * Host register block. Writes land on the next edge and reads are combinational.
 * Drives start, program address, master select, mask and acknowledge.
 */
`timescale 1ns/1ns
`default_nettype none

module vxe_regio (
	input  wire                  clk,
	input  wire                  nrst,
	input  vxe_pkg::reg_idx_t    i_wreg_idx,
	input  vxe_pkg::word_t       i_wdata,
	input  wire                  i_wenable,
	input  vxe_pkg::reg_idx_t    i_rreg_idx,
	input  wire                  i_renable,
	output vxe_pkg::word_t       o_rdata,
	input  wire                  i_cu_busy,
	input  vxe_pkg::pgm_addr_t   i_cu_last_instr_addr,
	input  vxe_pkg::instr_t      i_cu_last_instr_data,
	input  vxe_pkg::fault_t      i_cu_fault,
	output vxe_pkg::pgm_addr_t   o_cu_pgm_addr,
	output logic                 o_cu_start,
	input  vxe_pkg::intr_t       i_intu_raw,
	input  vxe_pkg::intr_t       i_intu_act,
	output vxe_pkg::intr_t       o_intu_msk,
	output logic                 o_intu_ack_vld,
	output vxe_pkg::intr_t       o_intu_ack,
	output logic                 o_start_ignored,
	output logic                 o_cu_mas_sel
);
	import vxe_pkg::*;

	logic [28:0] addr_lo;	/* Byte address bits 31..3. */
	logic [4:0]  addr_hi;	/* Byte address bits 36..32. */
	intr_t       msk;

	assign o_cu_pgm_addr = {addr_hi, addr_lo, 3'b000};
	assign o_intu_msk = msk;

	/* Config registers and one-cycle pulses. */
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			addr_lo <= '0;
			addr_hi <= '0;
			msk <= '0;
			o_cu_mas_sel <= 1'b0;
			o_cu_start <= 1'b0;
			o_start_ignored <= 1'b0;
			o_intu_ack_vld <= 1'b0;
		end
		else
		begin
			o_cu_start <= 1'b0;	/* Pulses by default. */
			o_start_ignored <= 1'b0;
			o_intu_ack_vld <= 1'b0;
			if (i_wenable)
			begin
				case (i_wreg_idx)
				REG_CTRL:        o_cu_mas_sel <= i_wdata[0];
				REG_INTR_MSK:    msk <= i_wdata[3:0];
				REG_INTR_ACT:    o_intu_ack_vld <= 1'b1;
				REG_PGM_ADDR_LO: addr_lo <= i_wdata[31:3];
				REG_PGM_ADDR_HI: addr_hi <= i_wdata[4:0];
				REG_START:
				begin
					o_cu_start <= ~i_cu_busy;	/* Busy gates start. */
					o_start_ignored <= i_cu_busy;
				end
				default: ;
				endcase
			end
		end
	end

	/* Acknowledge vector that goes with o_intu_ack_vld. */
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			o_intu_ack <= '0;
		else if (i_wenable && i_wreg_idx == REG_INTR_ACT)
			o_intu_ack <= i_wdata[3:0];
	end

	/* Read mux. */
	always_comb
	begin
		o_rdata = DEAD_WORD;
		if (i_renable)
		begin
			case (i_rreg_idx)
			REG_ID:                  o_rdata = VXENGINE_ID;
			REG_CTRL:                o_rdata = {31'h0, o_cu_mas_sel};
			REG_STATUS:              o_rdata = {31'h0, i_cu_busy};
			REG_INTR_ACT:            o_rdata = {28'h0, i_intu_act};
			REG_INTR_MSK:            o_rdata = {28'h0, msk};
			REG_INTR_RAW:            o_rdata = {28'h0, i_intu_raw};
			REG_PGM_ADDR_LO:         o_rdata = {addr_lo, 3'b000};
			REG_PGM_ADDR_HI:         o_rdata = {27'h0, addr_hi};
			REG_START:               o_rdata = WO_WORD;
			REG_FAULT_INSTR_ADDR_LO: o_rdata = {i_cu_last_instr_addr[31:3], 3'b000};
			REG_FAULT_INSTR_ADDR_HI: o_rdata = {27'h0, i_cu_last_instr_addr[36:32]};
			REG_FAULT_INSTR_LO:      o_rdata = i_cu_last_instr_data[31:0];
			REG_FAULT_INSTR_HI:      o_rdata = i_cu_last_instr_data[63:32];
			REG_FAULT_CODE:          o_rdata = {30'h0, i_cu_fault};
			default:                 o_rdata = DEAD_WORD;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/vxe_top.sv
/*
 * Engine top level. Register bus, memory write port and irq
 * as plain ports. Wires the register block, CU, interrupt unit and memory.
 */
`timescale 1ns/1ns
`default_nettype none

module vxe_top (
	input  wire                clk,
	input  wire                nrst,
	input  vxe_pkg::reg_idx_t  i_wreg_idx,
	input  vxe_pkg::word_t     i_wdata,
	input  wire                i_wenable,
	input  vxe_pkg::reg_idx_t  i_rreg_idx,
	input  wire                i_renable,
	output vxe_pkg::word_t     o_rdata,
	input  vxe_pkg::mem_idx_t  i_mem_widx,
	input  vxe_pkg::instr_t    i_mem_wdata,
	input  wire                i_mem_wenable,
	output wire                o_irq
);
	import vxe_pkg::*;

	wire       cu_start, cu_busy, mas_sel;
	pgm_addr_t pgm_addr, last_addr;
	instr_t    last_data;
	fault_t    fault;
	intr_t     msk, ack, raw, act, events;
	wire       ack_vld, start_ign, done_evt, fault_evt, wr_ign;

	vxe_fetch_if fetch_if ();

	/* Bit order matches intr_t. */
	assign events = {wr_ign, start_ign, fault_evt, done_evt};

	vxe_regio i_regio (
		.clk(clk), .nrst(nrst),
		.i_wreg_idx(i_wreg_idx), .i_wdata(i_wdata), .i_wenable(i_wenable),
		.i_rreg_idx(i_rreg_idx), .i_renable(i_renable), .o_rdata(o_rdata),
		.i_cu_busy(cu_busy), .i_cu_last_instr_addr(last_addr),
		.i_cu_last_instr_data(last_data), .i_cu_fault(fault),
		.o_cu_pgm_addr(pgm_addr), .o_cu_start(cu_start),
		.i_intu_raw(raw), .i_intu_act(act), .o_intu_msk(msk),
		.o_intu_ack_vld(ack_vld), .o_intu_ack(ack),
		.o_start_ignored(start_ign), .o_cu_mas_sel(mas_sel)
	);

	vxe_intu i_intu (
		.clk(clk), .nrst(nrst), .i_events(events), .i_msk(msk),
		.i_ack_vld(ack_vld), .i_ack(ack),
		.o_raw(raw), .o_act(act), .o_irq(o_irq)
	);

	vxe_cu i_cu (
		.clk(clk), .nrst(nrst), .i_start(cu_start), .i_pgm_addr(pgm_addr),
		.o_busy(cu_busy), .o_last_instr_addr(last_addr),
		.o_last_instr_data(last_data), .o_fault(fault),
		.o_done_evt(done_evt), .o_fault_evt(fault_evt), .fetch(fetch_if.master)
	);

	vxe_memhub i_memhub (
		.clk(clk), .i_mas_sel(mas_sel), .i_host_widx(i_mem_widx),
		.i_host_wdata(i_mem_wdata), .i_host_wenable(i_mem_wenable),
		.o_wr_ignored_evt(wr_ign), .fetch(fetch_if.slave)
	);

endmodule

`default_nettype wire

//--- verification/tb_vxe.sv
/*
 * Testbench for the vector engine control slice. Register traffic and
 * programs come from an LFSR and are checked against a model kept here.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_vxe;
	import vxe_pkg::*;

	logic     clk, nrst;
	reg_idx_t i_wreg_idx, i_rreg_idx;
	word_t    i_wdata, o_rdata;
	logic     i_wenable, i_renable, i_mem_wenable;
	mem_idx_t i_mem_widx;
	instr_t   i_mem_wdata;
	wire      o_irq;

	logic [15:0] lfsr = 16'd90;	/* LFSR seed. */
	int          fail_count = 0;

	instr_t    m_mem [MEM_DEPTH];	/* Model memory image. */
	intr_t     m_raw, m_msk;	/* Pending bits and mask. */
	logic      m_sel;	/* Master select. */
	pgm_addr_t m_addr, m_last_addr;	/* Start address and last executed. */
	instr_t    m_last_data;
	fault_t    m_fault;

	vxe_top i_vxe_top (
		.clk(clk), .nrst(nrst),
		.i_wreg_idx(i_wreg_idx), .i_wdata(i_wdata), .i_wenable(i_wenable),
		.i_rreg_idx(i_rreg_idx), .i_renable(i_renable), .o_rdata(o_rdata),
		.i_mem_widx(i_mem_widx), .i_mem_wdata(i_mem_wdata),
		.i_mem_wenable(i_mem_wenable), .o_irq(o_irq)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;	/* 20 ns period. */
	end

	/* Galois step that returns the bit shifted out. */
	function automatic logic lfsr_step();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 16'hb400;	/* Taps 16, 14, 13, 11. */
		return b;
	endfunction

	function automatic word_t rand_bits(input int n);
		word_t r;
		r = '0;
		for (int i = 0; i < n; i++)
			r = {r[30:0], lfsr_step()};	/* One step per bit. */
		return r;
	endfunction

	/* Given opcode with a random payload. */
	function automatic instr_t rand_instr(input logic [7:0] op);
		word_t hi;
		word_t lo;
		hi = rand_bits(24);
		lo = rand_bits(32);
		return {op, hi[23:0], lo};
	endfunction

	task automatic abort_run();
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at the first failing check");
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (exp !== act)
		begin
			$display("error %s: expected %h, actual %h", name, exp, act);
			fail_count++;
			abort_run();
		end
	endtask

	task automatic check_intr(input string name, input intr_t exp, input intr_t act);
		if (exp !== act)
		begin
			$display("error %s: expected %b, actual %b", name, exp, act);
			fail_count++;
			abort_run();
		end
	endtask

	task automatic check_instr(input string name, input instr_t exp, input instr_t act);
		if (exp !== act)
		begin
			$display("error %s: expected %h, actual %h", name, exp, act);
			fail_count++;
			abort_run();
		end
	endtask

	/* Register write that lands on the next rising edge. */
	task automatic reg_write(input reg_idx_t idx, input word_t d);
		@(negedge clk);
		i_wreg_idx = idx;
		i_wdata = d;
		i_wenable = 1'b1;
		@(negedge clk);
		i_wenable = 1'b0;
		case (idx)	/* Model of the writable registers. */
		REG_CTRL:        m_sel = d[0];
		REG_INTR_MSK:    m_msk = d[3:0];
		REG_INTR_ACT:    m_raw = m_raw & ~d[3:0];
		REG_PGM_ADDR_LO: m_addr[31:0] = {d[31:3], 3'b000};
		REG_PGM_ADDR_HI: m_addr[36:32] = d[4:0];
		default: ;
		endcase
	endtask

	task automatic reg_read(input reg_idx_t idx, output word_t d);
		@(negedge clk);
		i_rreg_idx = idx;
		#5;
		d = o_rdata;	/* Sampled mid low phase. */
	endtask

	task automatic check_reg(input string name, input reg_idx_t idx, input word_t exp);
		word_t d;
		reg_read(idx, d);
		check_word(name, exp, d);
	endtask

	task automatic mem_write(input mem_idx_t idx, input instr_t d);
		@(negedge clk);
		i_mem_widx = idx;
		i_mem_wdata = d;
		i_mem_wenable = 1'b1;
		@(negedge clk);
		i_mem_wenable = 1'b0;
		if (m_sel)
			m_raw[3] = 1'b1;	/* Dropped while the CU owns memory. */
		else
			m_mem[idx] = d;
	endtask

	/* Walks the model memory from the start address. */
	task automatic model_run();
		pgm_addr_t pc;
		logic      fin;
		instr_t    w;
		pc = m_addr;
		m_fault = '0;
		fin = 1'b0;
		while (!fin)
		begin
			m_last_addr = pc;
			if (pc[36:3] >= 34'(MEM_DEPTH))
			begin
				m_fault = 2'b10;	/* Past the end of memory. */
				m_raw[1] = 1'b1;
				fin = 1'b1;
			end
			else
			begin
				w = m_mem[pc[10:3]];
				m_last_data = w;
				if (w[63:56] == OP_NOP)
					pc = pc + 37'd8;
				else if (w[63:56] == OP_END)
				begin
					m_raw[0] = 1'b1;
					fin = 1'b1;
				end
				else
				begin
					m_fault = 2'b01;	/* Illegal opcode. */
					m_raw[1] = 1'b1;
					fin = 1'b1;
				end
			end
		end
	endtask

	task automatic wait_not_busy(input string name);
		word_t st;
		int    n;
		n = 0;
		reg_read(REG_STATUS, st);
		while (st[0] && n < 500)
		begin
			reg_read(REG_STATUS, st);
			n++;
		end
		if (st[0])
		begin
			$display("%s: engine still busy after %0d status polls", name, n);
			fail_count++;
			abort_run();
		end
	endtask

	/* NOPs and one closing word. */
	task automatic load_program(input mem_idx_t base, input int n_nop, input instr_t last);
		reg_write(REG_CTRL, 32'd0);	/* Host owns memory. */
		for (int i = 0; i < n_nop; i++)
			mem_write(base + mem_idx_t'(i), rand_instr(OP_NOP));
		mem_write(base + mem_idx_t'(n_nop), last);
	endtask

	task automatic set_start(input mem_idx_t idx);
		reg_write(REG_PGM_ADDR_LO, {21'h0, idx, 3'b000});
		reg_write(REG_PGM_ADDR_HI, 32'h0);
	endtask

	task automatic run_program(input string name, input logic second_start);
		word_t lo, hi, d;
		reg_write(REG_CTRL, 32'd1);	/* Hand memory to the CU. */
		model_run();
		reg_write(REG_START, 32'd0);
		if (second_start)
		begin
			reg_write(REG_START, 32'd0);	/* Lands while busy. */
			m_raw[2] = 1'b1;
		end
		wait_not_busy(name);
		check_reg({name, " fault code"}, REG_FAULT_CODE, {30'h0, m_fault});
		reg_read(REG_FAULT_INSTR_LO, lo);
		reg_read(REG_FAULT_INSTR_HI, hi);
		check_instr({name, " instr"}, m_last_data, {hi, lo});
		check_reg({name, " addr lo"}, REG_FAULT_INSTR_ADDR_LO, m_last_addr[31:0]);
		check_reg({name, " addr hi"}, REG_FAULT_INSTR_ADDR_HI, {27'h0, m_last_addr[36:32]});
		reg_read(REG_INTR_RAW, d);
		check_intr({name, " raw"}, m_raw, d[3:0]);
	endtask

	initial
	begin
		repeat (20000) @(posedge clk);
		$display("simulation did not finish within the cycle limit");
		abort_run();
	end

	initial
	begin
		word_t      d;
		mem_idx_t   base, base3;
		int         n, n3;
		logic [7:0] op;
		reg_idx_t   cfg [4];
		nrst = 1'b0;
		i_wreg_idx = '0;
		i_wdata = '0;
		i_wenable = 1'b0;
		i_rreg_idx = '0;
		i_renable = 1'b1;
		i_mem_widx = '0;
		i_mem_wdata = '0;
		i_mem_wenable = 1'b0;
		m_raw = '0;
		m_msk = '0;
		m_sel = 1'b0;
		m_addr = '0;
		m_last_addr = '0;
		m_last_data = '0;
		m_fault = '0;
		cfg = '{REG_CTRL, REG_INTR_MSK, REG_PGM_ADDR_LO, REG_PGM_ADDR_HI};
		repeat (10) @(negedge clk);
		nrst = 1'b1;

		/* Reset values. */
		check_reg("id", REG_ID, VXENGINE_ID);
		for (int i = 1; i <= 13; i++)
			check_reg("reset value", reg_idx_t'(i),
				(reg_idx_t'(i) == REG_START) ? WO_WORD : 32'h0);
		check_reg("unused index", reg_idx_t'(14 + rand_bits(9)), DEAD_WORD);
		@(negedge clk);
		i_renable = 1'b0;
		check_reg("read disabled", REG_ID, DEAD_WORD);
		@(negedge clk);
		i_renable = 1'b1;

		/* Random config writes with each register hit twice. */
		for (int i = 0; i < 8; i++)
		begin
			reg_write(cfg[i % 4], rand_bits(32));
			check_reg("ctrl", REG_CTRL, {31'h0, m_sel});
			check_reg("mask", REG_INTR_MSK, {28'h0, m_msk});
			check_reg("addr lo", REG_PGM_ADDR_LO, m_addr[31:0]);
			check_reg("addr hi", REG_PGM_ADDR_HI, {27'h0, m_addr[36:32]});
		end

		/* NOP program ending in END. */
		base3 = mem_idx_t'(rand_bits(6));
		n3 = int'(rand_bits(3)) + 1;
		load_program(base3, n3, rand_instr(OP_END));
		set_start(base3);
		run_program("nop run", 1'b0);

		/* Illegal opcode and running off the end of memory. */
		d = rand_bits(8);
		op = d[7:0];
		if (op == OP_NOP || op == OP_END)
			op = op + 8'd2;
		base = mem_idx_t'(128 + rand_bits(6));
		n = int'(rand_bits(2));
		load_program(base, n, rand_instr(op));
		set_start(base);
		run_program("illegal op", 1'b0);
		load_program(8'd252, 3, rand_instr(OP_NOP));
		set_start(8'd252);
		run_program("range", 1'b0);
		reg_write(REG_PGM_ADDR_HI, 32'd1 + rand_bits(4));	/* Above 4 GB. */
		run_program("high addr", 1'b0);

		/* Ignored start and ignored memory write. */
		mem_write(base3 + mem_idx_t'(n3), rand_instr(8'hff));
		set_start(base3);
		run_program("busy start", 1'b1);

		/* Mask, irq line and acknowledge. */
		repeat (6)
		begin
			reg_write(REG_INTR_MSK, rand_bits(4));
			reg_read(REG_INTR_ACT, d);
			check_intr("active", m_raw & m_msk, d[3:0]);
			check_intr("irq", intr_t'(|(m_raw & m_msk)), intr_t'(o_irq));
			reg_write(REG_INTR_ACT, rand_bits(4));
			reg_read(REG_INTR_RAW, d);
			check_intr("ack", m_raw, d[3:0]);
		end

		if (fail_count == 0)
		begin
			$display("ALL TESTS PASSED");
			$finish;
		end
		else
			abort_run();
	end

endmodule

`default_nettype wire

//--- vxe.f
src/vxe_pkg.sv
src/vxe_fetch_if.sv
src/vxe_regio.sv
src/vxe_intu.sv
src/vxe_cu.sv
src/vxe_memhub.sv
src/vxe_top.sv
verification/tb_vxe.sv
